// File: cdc_fifo.f
common/cdc_fifo_pkg.sv
source/gray_sync.sv
cdc_fifo_ctrl/cdc_fifo_push_ctrl.sv
cdc_fifo_ctrl/cdc_fifo_pop_ctrl.sv
source/ram_flops_1r1w.sv
source/cdc_fifo_flops_push_credit.sv
sim/cdc_fifo_sva.sv
sim/tb_cdc_fifo.sv

// File: cdc_fifo_ctrl/cdc_fifo_pop_ctrl.sv
`timescale 1ns/1ps

module cdc_fifo_pop_ctrl (
  input  logic                  pop_clk,
  input  logic                  rst_n,
  input  cdc_fifo_pkg::ptr_t    wptr_sync,
  output cdc_fifo_pkg::addr_t   rd_addr,
  input  cdc_fifo_pkg::data_t   rd_data,
  output cdc_fifo_pkg::ptr_t    rptr,
  input  logic                  pop_ready,
  output logic                  pop_valid,
  output cdc_fifo_pkg::data_t   pop_data,
  output logic                  pop_empty,
  output cdc_fifo_pkg::count_t  pop_items
);

  // Load pointer, the next RAM entry to move into the output register
  cdc_fifo_pkg::ptr_t   rd_ptr;

  // RAM entries written but not yet loaded into the output register
  cdc_fifo_pkg::count_t ram_items;

  logic pop_xfer;
  logic load;

  // ------------------------------------------------
  // Read side of the RAM
  // ------------------------------------------------

  assign rd_addr   = rd_ptr[cdc_fifo_pkg::ADDR_WIDTH-1:0];
  assign ram_items = cdc_fifo_pkg::count_t'(wptr_sync - rd_ptr);

  // Handshake on the pop interface
  assign pop_xfer = pop_valid & pop_ready;

  // Fill the output register when it is empty or drains this cycle
  assign load = (ram_items != '0) && (!pop_valid || pop_ready);

  // ------------------------------------------------
  // Pointers and output valid
  // ------------------------------------------------

  // rptr only moves once an entry has left through the pop interface,
  // so the slot behind the output register stays reserved on the push side
  // and the FIFO never holds more than FIFO_DEPTH entries in total
  always_ff @(posedge pop_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr    <= '0;
      rptr      <= '0;
      pop_valid <= 1'b0;
    end else begin
      if (load) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (pop_xfer) begin
        rptr <= rptr + 1'b1;
      end
      // A load keeps valid high, a pop with nothing behind it clears it
      if (load) begin
        pop_valid <= 1'b1;
      end else if (pop_ready) begin
        pop_valid <= 1'b0;
      end
    end
  end

  // ------------------------------------------------
  // Output data register
  // ------------------------------------------------

  // Holds while the receiver stalls, since load needs pop_ready then
  always_ff @(posedge pop_clk) begin
    if (load) begin
      pop_data <= rd_data;
    end
  end

  // ------------------------------------------------
  // Status
  // ------------------------------------------------

  // Counts the RAM entries plus the one in the output register, which is
  // the same as the write pointer minus the popped pointer
  assign pop_items = cdc_fifo_pkg::count_t'(wptr_sync - rptr);
  assign pop_empty = (pop_items == '0);

endmodule

// File: cdc_fifo_ctrl/cdc_fifo_push_ctrl.sv
`timescale 1ns/1ps

module cdc_fifo_push_ctrl (
  input  logic                   push_clk,
  input  logic                   rst_n,
  input  logic                   push_valid,
  input  cdc_fifo_pkg::data_t    push_data,
  input  cdc_fifo_pkg::count_t   credit_withhold,
  input  cdc_fifo_pkg::ptr_t     rptr_sync,
  output cdc_fifo_pkg::ptr_t     wptr,
  output cdc_fifo_pkg::ram_wr_t  ram_wr,
  output logic                   push_credit,
  output cdc_fifo_pkg::count_t   credit_count,
  output logic                   push_full,
  output cdc_fifo_pkg::count_t   push_slots
);

  // Write pointer after this cycle's push, if any
  cdc_fifo_pkg::ptr_t   wptr_next;

  // Synchronized read pointer as seen on the previous cycle
  cdc_fifo_pkg::ptr_t   rptr_sync_q;

  // Entries released by the pop side since the previous cycle
  cdc_fifo_pkg::count_t rptr_adv;

  // Entries in use once this cycle's push lands
  cdc_fifo_pkg::count_t used_next;
  cdc_fifo_pkg::count_t slots_next;

  // Ungranted free slots after this cycle
  cdc_fifo_pkg::count_t credit_next;

  // ------------------------------------------------
  // RAM write port
  // ------------------------------------------------

  // The sender only pushes with credit in hand, so every push has a free slot
  always_comb begin
    ram_wr.en   = push_valid;
    ram_wr.addr = wptr[cdc_fifo_pkg::ADDR_WIDTH-1:0];
    ram_wr.data = push_data;
  end

  assign wptr_next = wptr + cdc_fifo_pkg::ptr_t'(push_valid);

  // ------------------------------------------------
  // Slot and credit accounting
  // ------------------------------------------------

  // Modulo pointer difference, the wrap bit makes a full FIFO read as FIFO_DEPTH
  assign used_next  = cdc_fifo_pkg::count_t'(wptr_next - rptr_sync);
  assign slots_next = cdc_fifo_pkg::count_t'(cdc_fifo_pkg::FIFO_DEPTH) - used_next;

  // Several pops can show up at once when the clocks differ a lot
  assign rptr_adv = cdc_fifo_pkg::count_t'(rptr_sync - rptr_sync_q);

  // A credit leaves the counter in the cycle that push_credit is high
  assign credit_next = credit_count + rptr_adv - cdc_fifo_pkg::count_t'(push_credit);

  always_ff @(posedge push_clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr         <= '0;
      rptr_sync_q  <= '0;
      push_slots   <= cdc_fifo_pkg::count_t'(cdc_fifo_pkg::FIFO_DEPTH);
      // Reads as full while held in reset so nothing is pushed then
      push_full    <= 1'b1;
      credit_count <= cdc_fifo_pkg::count_t'(cdc_fifo_pkg::FIFO_DEPTH);
      push_credit  <= 1'b0;
    end else begin
      wptr         <= wptr_next;
      rptr_sync_q  <= rptr_sync;
      push_slots   <= slots_next;
      push_full    <= (slots_next == '0);
      credit_count <= credit_next;
      // Grant another credit only while the remaining count stays above
      // the level the sender wants held back
      push_credit  <= (credit_next > credit_withhold);
    end
  end

endmodule

// File: common/cdc_fifo_pkg.sv
package cdc_fifo_pkg;

  // ------------------------------------------------
  // Sizes
  // ------------------------------------------------

  // Number of FIFO entries, must be a power of two so pointers wrap cleanly
  localparam int FIFO_DEPTH = 8;

  // Width of one FIFO entry
  localparam int DATA_WIDTH = 16;

  // RAM address width, enough to index every entry
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

  // Pointers carry one extra wrap bit to tell full from empty
  localparam int PTR_WIDTH = ADDR_WIDTH + 1;

  // Counts must be able to hold the value FIFO_DEPTH itself
  localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

  // Destination flops in each Gray pointer synchronizer
  localparam int SYNC_STAGES = 2;

  // ------------------------------------------------
  // Scalar types
  // ------------------------------------------------

  typedef logic [DATA_WIDTH-1:0]  data_t;
  typedef logic [ADDR_WIDTH-1:0]  addr_t;

  // Used for both binary and Gray encoded pointers
  typedef logic [PTR_WIDTH-1:0]   ptr_t;

  // Slot, item, credit and withhold counts
  typedef logic [COUNT_WIDTH-1:0] count_t;

  // ------------------------------------------------
  // RAM port structs
  // ------------------------------------------------

  // Write port of the flop RAM, driven from the push domain
  typedef struct packed {
    logic  en;
    addr_t addr;
    data_t data;
  } ram_wr_t;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the FIFO testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

top=tb_cdc_fifo
build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert \
  --top-module "$top" \
  -Mdir "$build_dir" \
  -f cdc_fifo.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/V$top" > "$log" 2>&1
sim_status=$?
cat "$log"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
fi

# The run counts as passed only when the testbench printed its pass line
if grep -qx '>>> PASS' "$log"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

// File: sim/cdc_fifo_sva.sv
`timescale 1ns/1ps

module cdc_fifo_sva (
  input logic                 push_clk,
  input logic                 pop_clk,
  input logic                 rst_n,
  input logic                 push_credit,
  input logic                 push_valid,
  input cdc_fifo_pkg::count_t credit_withhold,
  input cdc_fifo_pkg::count_t credit_count,
  input logic                 pop_ready,
  input logic                 pop_valid,
  input cdc_fifo_pkg::data_t  pop_data
);

  // Count of assertion failures seen so far
  int fail_count = 0;

  // Credits granted to the sender and not yet spent
  int outstanding;

  always_ff @(posedge push_clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(push_credit) - int'(push_valid);
    end
  end

  // A stalled head entry holds until the receiver takes it
  pop_hold: assert property (@(posedge pop_clk) disable iff (!rst_n)
    pop_valid && !pop_ready |=> pop_valid && $stable(pop_data))
    else begin
      fail_count++;
      $error("pop_valid or pop_data moved while stalled");
    end

  // A credit granted in the same cycle may be spent in it
  push_has_credit: assert property (@(posedge push_clk) disable iff (!rst_n)
    push_valid |-> (outstanding + int'(push_credit)) > 0)
    else begin
      fail_count++;
      $error("push_valid without an outstanding credit");
    end

  credit_above_withhold: assert property (@(posedge push_clk) disable iff (!rst_n)
    push_credit |-> credit_count > credit_withhold)
    else begin
      fail_count++;
      $error("push_credit with credit_count at or below withhold");
    end

endmodule

bind cdc_fifo_flops_push_credit cdc_fifo_sva i_sva (
  .push_clk       (push_clk),
  .pop_clk        (pop_clk),
  .rst_n          (rst_n),
  .push_credit    (push_credit),
  .push_valid     (push_valid),
  .credit_withhold(credit_withhold),
  .credit_count   (credit_count),
  .pop_ready      (pop_ready),
  .pop_valid      (pop_valid),
  .pop_data       (pop_data)
);

// File: sim/tb_cdc_fifo.sv
`timescale 1ns/1ps

module tb_cdc_fifo;

  // ------------------------------------------------
  // Test constants
  // ------------------------------------------------

  localparam int PUSH_HALF    = 20;
  localparam int POP_HALF     = 28;
  localparam int DRIVE_DELAY  = 2;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_PUSHES   = 400;
  localparam int QUIET_CYCLES = 20;
  localparam int WITHHOLD     = 3;
  localparam int DEPTH        = cdc_fifo_pkg::FIFO_DEPTH;

  // Forty push cycles per push is far beyond the slowest pop rate
  localparam int TIMEOUT_CYCLES = NUM_PUSHES * 40;
  localparam logic [31:0] SEED  = 32'h92eb;

  // Receiver behavior for pop_ready
  localparam int READY_RANDOM = 0;
  localparam int READY_LOW    = 1;
  localparam int READY_HIGH   = 2;

  logic                 push_clk;
  logic                 pop_clk;
  logic                 rst_n;
  logic                 push_credit;
  logic                 push_valid;
  cdc_fifo_pkg::data_t  push_data;
  cdc_fifo_pkg::count_t credit_withhold;
  cdc_fifo_pkg::count_t credit_count;
  logic                 push_full;
  cdc_fifo_pkg::count_t push_slots;
  logic                 pop_ready;
  logic                 pop_valid;
  cdc_fifo_pkg::data_t  pop_data;
  logic                 pop_empty;
  cdc_fifo_pkg::count_t pop_items;

  // Entries pushed and not yet popped, in order
  cdc_fifo_pkg::data_t  model_q[$];
  int                   credits;
  int                   push_budget;
  int                   ready_mode;
  int                   cycle_count;
  logic [31:0]          push_rng;
  logic [31:0]          pop_rng;

  cdc_fifo_flops_push_credit i_dut (.*);

  initial begin
    push_clk = 1'b0;
    forever #PUSH_HALF push_clk = ~push_clk;
  end

  initial begin
    pop_clk = 1'b0;
    forever #POP_HALF pop_clk = ~pop_clk;
  end

  // ------------------------------------------------
  // Helpers
  // ------------------------------------------------

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_data(input cdc_fifo_pkg::data_t got, input cdc_fifo_pkg::data_t exp,
                            input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_count(input cdc_fifo_pkg::count_t got, input cdc_fifo_pkg::count_t exp,
                             input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic wait_push_cycles(input int n);
    repeat (n) @(posedge push_clk);
    #DRIVE_DELAY;
  endtask

  task automatic wait_pop_cycles(input int n);
    repeat (n) @(posedge pop_clk);
    #DRIVE_DELAY;
  endtask

  // Both domains share rst_n, so release lands 2 ns after a push edge,
  // which never meets a pop edge with these two periods
  task automatic apply_reset(input cdc_fifo_pkg::count_t withhold);
    @(posedge push_clk);
    #DRIVE_DELAY;
    rst_n = 1'b0;
    credit_withhold = withhold;
    model_q.delete();
    repeat (RESET_CYCLES) @(posedge push_clk);
    #DRIVE_DELAY;
    check_flag(push_full, 1'b1, "push_full in reset");
    check_count(credit_count, cdc_fifo_pkg::count_t'(DEPTH), "credit_count in reset");
    rst_n = 1'b1;
  endtask

  // All pushes issued and every entry seen by the receiver
  task automatic wait_for_drain();
    while (push_budget > 0 || model_q.size() > 0) @(posedge push_clk);
    #DRIVE_DELAY;
  endtask

  // ------------------------------------------------
  // Sender, receiver and cycle limit
  // ------------------------------------------------

  // Counts one credit for each cycle with push_credit high and may spend
  // it in that same cycle
  initial begin
    push_valid = 1'b0;
    push_data  = '0;
    credits    = 0;
    push_rng   = SEED;
    forever begin
      @(posedge push_clk);
      #DRIVE_DELAY;
      if (!rst_n) begin
        credits    = 0;
        push_valid = 1'b0;
      end else begin
        if (push_credit) credits++;
        if (credits + model_q.size() > DEPTH) begin
          stop_on_error("Sender credits plus queued entries exceed the FIFO depth");
        end
        push_rng = xorshift(push_rng);
        if (push_budget > 0 && credits > 0 && push_rng[1:0] != 2'b00) begin
          push_data  = push_rng[31:16];
          push_valid = 1'b1;
          credits--;
          push_budget--;
          model_q.push_back(push_data);
        end else begin
          push_valid = 1'b0;
        end
      end
    end
  end

  // pop_valid and pop_data are stable between edges, so a transfer that
  // completes on the next edge is checked as soon as pop_ready is set
  initial begin
    pop_ready = 1'b0;
    pop_rng   = xorshift(SEED);
    forever begin
      @(posedge pop_clk);
      #DRIVE_DELAY;
      pop_rng = xorshift(pop_rng);
      case (ready_mode)
        READY_LOW:  pop_ready = 1'b0;
        READY_HIGH: pop_ready = 1'b1;
        default:    pop_ready = pop_rng[0];
      endcase
      if (rst_n && pop_valid && pop_ready) begin
        if (model_q.size() == 0) begin
          stop_on_error("An entry was popped while the model queue was empty");
        end else begin
          check_data(pop_data, model_q.pop_front(), "pop_data");
        end
      end
    end
  end

  initial begin
    cycle_count = 0;
    forever begin
      @(posedge push_clk);
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
        stop_on_error("Timeout, the run did not finish within the push cycle limit");
      end
    end
  end

  // ------------------------------------------------
  // Test sequence
  // ------------------------------------------------

  initial begin
    rst_n           = 1'b0;
    credit_withhold = '0;
    push_budget     = 0;
    ready_mode      = READY_RANDOM;

    // Idle state after the first reset
    apply_reset('0);
    wait_push_cycles(2);
    check_flag(pop_valid, 1'b0, "pop_valid after reset");
    check_flag(pop_empty, 1'b1, "pop_empty after reset");
    check_count(push_slots, cdc_fifo_pkg::count_t'(DEPTH), "push_slots after reset");
    check_count(pop_items, '0, "pop_items after reset");

    // Random traffic, then every credit must come home
    push_budget = NUM_PUSHES;
    wait_for_drain();
    wait_push_cycles(QUIET_CYCLES);
    check_count(cdc_fifo_pkg::count_t'(credits), cdc_fifo_pkg::count_t'(DEPTH),
                "sender credits after drain");

    // Withheld credits stay in the counter
    apply_reset(cdc_fifo_pkg::count_t'(WITHHOLD));
    wait_push_cycles(QUIET_CYCLES);
    check_count(cdc_fifo_pkg::count_t'(credits), cdc_fifo_pkg::count_t'(DEPTH - WITHHOLD),
                "sender credits with withhold");
    check_count(credit_count, cdc_fifo_pkg::count_t'(WITHHOLD), "credit_count with withhold");

    // Releasing the withhold grants the rest, and a stalled receiver fills the FIFO
    ready_mode      = READY_LOW;
    credit_withhold = '0;
    push_budget     = DEPTH;
    while (push_budget > 0) @(posedge push_clk);
    wait_push_cycles(QUIET_CYCLES);
    check_flag(push_full, 1'b1, "push_full when full");
    check_count(push_slots, '0, "push_slots when full");
    check_count(cdc_fifo_pkg::count_t'(credits), '0, "sender credits when full");
    wait_pop_cycles(QUIET_CYCLES);
    check_count(pop_items, cdc_fifo_pkg::count_t'(DEPTH), "pop_items when full");
    ready_mode = READY_HIGH;
    wait_for_drain();
    wait_pop_cycles(4);
    check_flag(pop_empty, 1'b1, "pop_empty after drain");

    if (i_dut.i_sva.fail_count != 0) begin
      stop_on_error("One or more concurrent assertions failed");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

// File: source/cdc_fifo_flops_push_credit.sv
`timescale 1ns/1ps

module cdc_fifo_flops_push_credit (
  input  logic                  push_clk,
  input  logic                  pop_clk,
  input  logic                  rst_n,

  // Push side, credit/valid
  output logic                  push_credit,
  input  logic                  push_valid,
  input  cdc_fifo_pkg::data_t   push_data,
  input  cdc_fifo_pkg::count_t  credit_withhold,
  output cdc_fifo_pkg::count_t  credit_count,
  output logic                  push_full,
  output cdc_fifo_pkg::count_t  push_slots,

  // Pop side, ready/valid
  input  logic                  pop_ready,
  output logic                  pop_valid,
  output cdc_fifo_pkg::data_t   pop_data,
  output logic                  pop_empty,
  output cdc_fifo_pkg::count_t  pop_items
);

  // ------------------------------------------------
  // Crossing wires
  // ------------------------------------------------

  // Binary pointers in their own domain and their synchronized copies
  cdc_fifo_pkg::ptr_t    wptr;
  cdc_fifo_pkg::ptr_t    wptr_sync;
  cdc_fifo_pkg::ptr_t    rptr;
  cdc_fifo_pkg::ptr_t    rptr_sync;

  // RAM ports
  cdc_fifo_pkg::ram_wr_t ram_wr;
  cdc_fifo_pkg::addr_t   rd_addr;
  cdc_fifo_pkg::data_t   rd_data;

  // Push domain control and RAM write
  cdc_fifo_push_ctrl i_push_ctrl (
    .push_clk       (push_clk),
    .rst_n          (rst_n),
    .push_valid     (push_valid),
    .push_data      (push_data),
    .credit_withhold(credit_withhold),
    .rptr_sync      (rptr_sync),
    .wptr           (wptr),
    .ram_wr         (ram_wr),
    .push_credit    (push_credit),
    .credit_count   (credit_count),
    .push_full      (push_full),
    .push_slots     (push_slots)
  );

  // Write pointer travels push to pop
  gray_sync i_wptr_sync (
    .src_clk(push_clk),
    .dst_clk(pop_clk),
    .rst_n  (rst_n),
    .src_ptr(wptr),
    .dst_ptr(wptr_sync)
  );

  // Popped pointer travels pop to push and frees slots there
  gray_sync i_rptr_sync (
    .src_clk(pop_clk),
    .dst_clk(push_clk),
    .rst_n  (rst_n),
    .src_ptr(rptr),
    .dst_ptr(rptr_sync)
  );

  ram_flops_1r1w i_ram (
    .wr_clk (push_clk),
    .ram_wr (ram_wr),
    .rd_addr(rd_addr),
    .rd_data(rd_data)
  );

  // Pop domain control and output register
  cdc_fifo_pop_ctrl i_pop_ctrl (
    .pop_clk  (pop_clk),
    .rst_n    (rst_n),
    .wptr_sync(wptr_sync),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .rptr     (rptr),
    .pop_ready(pop_ready),
    .pop_valid(pop_valid),
    .pop_data (pop_data),
    .pop_empty(pop_empty),
    .pop_items(pop_items)
  );

endmodule

// File: source/gray_sync.sv
`timescale 1ns/1ps

module gray_sync (
  input  logic                src_clk,
  input  logic                dst_clk,
  input  logic                rst_n,
  input  cdc_fifo_pkg::ptr_t  src_ptr,
  output cdc_fifo_pkg::ptr_t  dst_ptr
);

  // Gray copy of the source pointer, held in the source domain
  cdc_fifo_pkg::ptr_t src_gray_q;

  // Destination synchronizer chain, stage 0 samples the source register
  cdc_fifo_pkg::ptr_t sync_q [cdc_fifo_pkg::SYNC_STAGES];

  // Each bit of the binary value is the XOR of all Gray bits at or above it
  function automatic cdc_fifo_pkg::ptr_t gray_to_bin(input cdc_fifo_pkg::ptr_t gray);
    cdc_fifo_pkg::ptr_t bin;
    bin[cdc_fifo_pkg::PTR_WIDTH-1] = gray[cdc_fifo_pkg::PTR_WIDTH-1];
    for (int i = cdc_fifo_pkg::PTR_WIDTH - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

  // Registering the Gray value keeps combinational glitches off the crossing
  // and guarantees only one bit moves per pointer step
  always_ff @(posedge src_clk or negedge rst_n) begin
    if (!rst_n) begin
      src_gray_q <= '0;
    end else begin
      src_gray_q <= src_ptr ^ (src_ptr >> 1);
    end
  end

  // The first stage may go metastable, later stages give it time to settle
  always_ff @(posedge dst_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < cdc_fifo_pkg::SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= src_gray_q;
      for (int i = 1; i < cdc_fifo_pkg::SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // Destination logic works in binary
  assign dst_ptr = gray_to_bin(sync_q[cdc_fifo_pkg::SYNC_STAGES-1]);

endmodule

// File: source/ram_flops_1r1w.sv
`timescale 1ns/1ps

module ram_flops_1r1w (
  input  logic                   wr_clk,
  input  cdc_fifo_pkg::ram_wr_t  ram_wr,
  input  cdc_fifo_pkg::addr_t    rd_addr,
  output cdc_fifo_pkg::data_t    rd_data
);

  // ------------------------------------------------
  // Storage
  // ------------------------------------------------

  // One flop word per FIFO entry
  cdc_fifo_pkg::data_t mem [cdc_fifo_pkg::FIFO_DEPTH];

  // Written only from the push domain
  always_ff @(posedge wr_clk) begin
    if (ram_wr.en) begin
      mem[ram_wr.addr] <= ram_wr.data;
    end
  end

  // ------------------------------------------------
  // Read port
  // ------------------------------------------------

  // The read address comes from the pop domain and the data goes
  // straight back there, so this path is a pop_clk path only.
  // An entry is stable long before its write pointer is seen across the
  // synchronizer, which is why the read needs no clock of its own
  assign rd_data = mem[rd_addr];

endmodule
